// ==== bench/tb_cpu.sv ====
`timescale 1ns/10ps

module tb_cpu;

    logic        clock;
    logic        reset;
    logic        enable;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic [15:0] address;
    logic        write_enable;
    logic        sync;
    int          write_count;
    logic [15:0] write_address;
    logic [7:0]  write_data;
    logic        stall_fault;
    logic [31:0] rng;
    logic        stall_mode;              // Random enable when set
    int          checked;                 // Writes compared so far
    int          write_base;              // Write count when the pass started
    logic [15:0] exp_address [$];
    logic [7:0]  exp_data [$];
    logic [7:0]  model_mem [0:65535];
    logic [7:0]  model_a;
    logic        model_n;
    logic        model_v;
    logic        model_z;
    logic        model_c;

    cpu_top dut (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .address      (address),
        .data_out     (data_out),
        .write_enable (write_enable),
        .sync         (sync)
    );

    tb_memory memory (
        .clock         (clock),
        .enable        (enable),
        .address       (address),
        .data_out      (data_out),
        .write_enable  (write_enable),
        .data_in       (data_in),
        .write_count   (write_count),
        .write_address (write_address),
        .write_data    (write_data),
        .stall_fault   (stall_fault)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;   // 8 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task stop_run;
        $display("Checks failed");
        $fatal(1);
    endtask

    task report_wrong(input string what);
        $display("[FAIL] %0t ns: %s", $time, what);
        stop_run();
    endtask

    task report_timeout(input string what);
        $display("Timed out: %s", what);
        stop_run();
    endtask

    // One clock, inputs change 1 ns after the edge
    task step;
        @(posedge clock);
        #1;
        if (stall_mode && !reset)
        begin
            rng    = xorshift(rng);
            enable = (rng[1:0] != 2'b00);   // Low about one cycle in four
        end
        else
            enable = 1'b1;
    endtask

    task set_nz(input logic [7:0] v);
        model_n = v[7];
        model_z = (v == 8'h00);
    endtask

    // ORA AND EOR ADC LDA CMP SBC on the model accumulator
    task model_alu(input logic [2:0] kind, input logic [7:0] m);
        logic [7:0] addend;
        logic       carry;
        logic [8:0] sum;
        begin
            addend = (kind == 3'd6 || kind == 3'd7) ? ~m : m;   // Subtract by complement
            carry  = (kind == 3'd6) ? 1'b1 : model_c;
            sum    = {1'b0, model_a} + {1'b0, addend} + {8'h00, carry};
            case (kind)
                3'd0: model_a = model_a | m;
                3'd1: model_a = model_a & m;
                3'd2: model_a = model_a ^ m;
                3'd5: model_a = m;
                3'd6: model_c = sum[8];        // CMP leaves A alone
                default:
                begin
                    model_v = (model_a[7] == addend[7]) && (sum[7] != model_a[7]);
                    model_c = sum[8];
                    model_a = sum[7:0];
                end
            endcase
            if (kind == 3'd6)
                set_nz(sum[7:0]);
            else
                set_nz(model_a);
        end
    endtask

    task model_shift(input logic [1:0] kind);
        logic out_bit;
        begin
            out_bit = kind[1] ? model_a[0] : model_a[7];
            case (kind)
                2'd0: model_a = {model_a[6:0], 1'b0};       // ASL
                2'd1: model_a = {model_a[6:0], model_c};    // ROL
                2'd2: model_a = {1'b0, model_a[7:1]};       // LSR
                default: model_a = {model_c, model_a[7:1]}; // ROR
            endcase
            model_c = out_bit;
            set_nz(model_a);
        end
    endtask

    // Instruction-level model that lists the writes the program must make
    task run_model;
        logic [15:0] pc;
        logic [15:0] target;
        logic [7:0]  op;
        logic [7:0]  operand;
        logic        taken;
        logic        done;
        int          steps;
        begin
            for (int i = 0; i < 65536; i++)
                model_mem[i] = memory.mem[i];
            pc      = {model_mem[16'hFFFD], model_mem[16'hFFFC]};
            model_a = 8'h00;
            {model_n, model_v, model_z, model_c} = 4'b0000;
            exp_address.delete();
            exp_data.delete();
            done  = 1'b0;
            steps = 0;
            while (!done && steps < 2000)
            begin
                op      = model_mem[pc];
                operand = model_mem[pc + 16'd1];
                steps++;
                case (op)
                    8'h4C:
                    begin
                        target = {model_mem[pc + 16'd2], operand};
                        done   = (target == pc);   // Jump to itself ends the program
                        pc     = target;
                    end
                    8'h18, 8'h38:
                    begin
                        model_c = op[5];
                        pc      = pc + 16'd1;
                    end
                    8'h0A, 8'h2A, 8'h4A, 8'h6A:
                    begin
                        model_shift(op[6:5]);
                        pc = pc + 16'd1;
                    end
                    8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0:
                    begin
                        case (op[7:6])
                            2'd0: taken = (model_n == op[5]);
                            2'd1: taken = (model_v == op[5]);
                            2'd2: taken = (model_c == op[5]);
                            default: taken = (model_z == op[5]);
                        endcase
                        pc = pc + 16'd2;
                        if (taken)
                            pc = pc + {{8{operand[7]}}, operand};
                    end
                    8'h09, 8'h29, 8'h49, 8'h69, 8'hA9, 8'hC9, 8'hE9:
                    begin
                        model_alu(op[7:5], operand);    // Immediate
                        pc = pc + 16'd2;
                    end
                    8'h05, 8'h25, 8'h45, 8'h65, 8'hA5, 8'hC5, 8'hE5:
                    begin
                        model_alu(op[7:5], model_mem[{8'h00, operand}]);
                        pc = pc + 16'd2;
                    end
                    8'h85:
                    begin
                        exp_address.push_back({8'h00, operand});
                        exp_data.push_back(model_a);
                        model_mem[{8'h00, operand}] = model_a;
                        pc = pc + 16'd2;
                    end
                    default: pc = pc + 16'd1;   // One-byte no-op
                endcase
            end
            if (!done)
                report_timeout("reference model never reached the final jump");
        end
    endtask

    // Compare each memory write with the model list
    always @(negedge clock)
    begin
        if (reset)
        begin
            write_base = write_count;
            checked    = 0;
        end
        else if (write_count != write_base + checked)
        begin
            assert (checked < exp_address.size())
                else report_wrong($sformatf("extra write %h to %h", write_data, write_address));
            assert (write_address === exp_address[checked] && write_data === exp_data[checked])
                else report_wrong($sformatf("write %0d is %h to %h, expected %h to %h",
                                            checked, write_data, write_address,
                                            exp_data[checked], exp_address[checked]));
            checked++;
        end
        assert (stall_fault === 1'b0)
            else report_wrong("bus changed inside a stalled cycle");
    end

    initial
    begin
        int wait_cycles;
        reset      = 1'b1;
        enable     = 1'b1;
        rng        = 32'd18198;
        stall_mode = 1'b0;
        checked    = 0;
        memory.load_program();
        run_model();
        // First pass without stalls, second with random stalls
        for (int pass = 0; pass < 2; pass++)
        begin
            stall_mode = (pass == 1);
            memory.load_program();
            reset = 1'b1;
            repeat (16)
            begin
                step();
                assert (write_enable === 1'b0 && sync === 1'b0)
                    else report_wrong("write_enable or sync high during reset");
            end
            reset       = 1'b0;
            wait_cycles = 0;
            while (sync !== 1'b1)
            begin
                step();
                wait_cycles++;
                if (wait_cycles > 40)
                    report_timeout("no opcode fetch after reset");
            end
            assert (address === {model_mem[16'hFFFD], model_mem[16'hFFFC]})
                else report_wrong($sformatf("first fetch from %h, not the reset vector", address));
            wait_cycles = 0;
            while (checked < exp_address.size())
            begin
                step();
                wait_cycles++;
                if (wait_cycles > 4000)
                    report_timeout("the program stopped before all expected writes");
            end
            repeat (40)
                step();   // Catch stray writes from the final loop
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== bench/tb_memory.sv ====
`timescale 1ns/10ps

module tb_memory (
    input  logic        clock,
    input  logic        enable,
    input  logic [15:0] address,
    input  logic [7:0]  data_out,
    input  logic        write_enable,
    output logic [7:0]  data_in,
    output int          write_count,     // Enabled writes seen so far
    output logic [15:0] write_address,
    output logic [7:0]  write_data,
    output logic        stall_fault      // Bus moved inside a stalled cycle
);

    logic [7:0]  mem [0:65535];
    logic [7:0]  main_code [$];     // Program at 0200
    logic [7:0]  cross_code [$];    // Target of JMP at 02F0
    logic [7:0]  shift_code [$];    // Forward page-crossing target at 0304
    logic [7:0]  back_code [$];     // Backward page-crossing target at 03F3
    logic [7:0]  loop_code [$];     // Backward branch source at 0400
    logic        held;
    logic [15:0] held_address;
    logic [7:0]  held_data;
    logic        held_write;

    assign data_in = mem[address];  // Asynchronous read

    initial
    begin
        write_count = 0;
        stall_fault = 1'b0;
        held        = 1'b0;
    end

    task load_program;
        logic [15:0] a;
        begin
            for (int i = 0; i < 65536; i++)
            begin
                a      = i;
                mem[i] = a[15:8] ^ a[7:0] ^ 8'hA5;  // Fill tied to the full address
            end
            main_code = '{8'hA9, 8'h5A, 8'h85, 8'h10, 8'hA5, 8'h80, 8'h85, 8'h11,
                          8'h09, 8'h81, 8'h85, 8'h12, 8'h25, 8'h81, 8'h85, 8'h13,
                          8'h49, 8'hFF, 8'h85, 8'h14, 8'h18, 8'h69, 8'h20, 8'h85,
                          8'h15, 8'h38, 8'hE5, 8'h80, 8'h85, 8'h16, 8'hA9, 8'hF0,
                          8'h18, 8'h69, 8'h20, 8'h85, 8'h17, 8'hA9, 8'h00, 8'h69,
                          8'h00, 8'h85, 8'h18, 8'hA9, 8'h44, 8'hC9, 8'h44, 8'hF0,
                          8'h02, 8'h85, 8'h20, 8'hD0, 8'h02, 8'h85, 8'h21, 8'h90,
                          8'h02, 8'h85, 8'h22, 8'hB0, 8'h02, 8'h85, 8'h23, 8'hA9,
                          8'h50, 8'h18, 8'h69, 8'h50, 8'h70, 8'h02, 8'h85, 8'h24,
                          8'h50, 8'h02, 8'h85, 8'h25, 8'hA9, 8'h80, 8'h30, 8'h02,
                          8'h85, 8'h26, 8'h10, 8'h02, 8'h85, 8'h27, 8'hA5, 8'h83,
                          8'h4C, 8'hF0, 8'h02, 8'h85, 8'h28};
            cross_code = '{8'h85, 8'h29, 8'hF0, 8'h10};   // STA then BEQ into page 03
            shift_code = '{8'hA9, 8'h81, 8'h0A, 8'h85, 8'h30, 8'h2A, 8'h85, 8'h31,
                           8'hA9, 8'h81, 8'h4A, 8'h85, 8'h32, 8'h6A, 8'h85, 8'h33,
                           8'hA9, 8'h80, 8'h0A, 8'h2A, 8'h85, 8'h34, 8'h4C, 8'h00,
                           8'h04};
            back_code  = '{8'hA9, 8'h77, 8'h85, 8'h35, 8'h4C, 8'hF7, 8'h03};  // Ends in JMP self
            loop_code  = '{8'h38, 8'hB0, 8'hF0};   // SEC, BCS back into page 03
            foreach (main_code[i])
                mem[16'h0200 + i] = main_code[i];
            foreach (cross_code[i])
                mem[16'h02F0 + i] = cross_code[i];
            foreach (shift_code[i])
                mem[16'h0304 + i] = shift_code[i];
            foreach (back_code[i])
                mem[16'h03F3 + i] = back_code[i];
            foreach (loop_code[i])
                mem[16'h0400 + i] = loop_code[i];
            mem[16'h0080] = 8'h3C;   // Zero-page operands
            mem[16'h0081] = 8'h0F;
            mem[16'h0083] = 8'h00;
            mem[16'hFFFC] = 8'h00;   // Reset vector 0200
            mem[16'hFFFD] = 8'h02;
        end
    endtask

    always @(posedge clock)
    begin
        if (enable && write_enable === 1'b1)
        begin
            mem[address]  <= data_out;
            write_address <= address;
            write_data    <= data_out;
            write_count   <= write_count + 1;
        end
        // Remember the bus of a stalled cycle
        held         <= !enable;
        held_address <= address;
        held_data    <= data_out;
        held_write   <= write_enable;
    end

    // After a stall the bus must repeat
    always @(negedge clock)
    begin
        if (held && (address !== held_address || data_out !== held_data
                     || write_enable !== held_write))
            stall_fault <= 1'b1;
    end

endmodule

// ==== rtl/cpu_alu.sv ====
`timescale 1ns/10ps

`include "cpu_config.svh"

module cpu_alu (
    input  logic [`CPU_DATA_WIDTH-1:0] a,
    input  logic [`CPU_DATA_WIDTH-1:0] b,
    input  logic                       carry_in,
    input  logic [2:0]                 operation,   // ORA AND EOR ADC STA LDA CMP SBC
    output logic [`CPU_DATA_WIDTH-1:0] result,
    output logic                       carry_out,
    output logic                       overflow
);

    logic                       subtract;
    logic                       carry;
    logic [`CPU_DATA_WIDTH-1:0] addend;
    logic [`CPU_DATA_WIDTH:0]   sum;

    assign subtract = (operation[2:1] == 2'b11);        // CMP and SBC
    assign carry    = (operation == 3'b110) | carry_in;  // CMP always subtracts without borrow
    assign addend   = subtract ? ~b : b;

    // Binary adder with carry out in the top bit
    assign sum = {1'b0, a} + {1'b0, addend} + {{`CPU_DATA_WIDTH{1'b0}}, carry};

    always_comb
    begin
        case (operation)
            3'b000:  result = a | b;             // ORA
            3'b001:  result = a & b;             // AND
            3'b010:  result = a ^ b;             // EOR
            3'b100:  result = a;                 // STA value
            3'b101:  result = b;                 // LDA
            default: result = sum[`CPU_DATA_WIDTH-1:0];  // ADC CMP SBC
        endcase
    end

    // Signed overflow when both operands agree in sign and the sum does not
    assign overflow  = (a[`CPU_DATA_WIDTH-1] ^ sum[`CPU_DATA_WIDTH-1])
                     & (addend[`CPU_DATA_WIDTH-1] ^ sum[`CPU_DATA_WIDTH-1]);
    assign carry_out = sum[`CPU_DATA_WIDTH];   // No borrow for CMP and SBC

endmodule

// ==== rtl/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Bus widths
`define CPU_DATA_WIDTH    8
`define CPU_ADDR_WIDTH    16

// PC at reset points at the low byte of the reset vector
`define CPU_RESET_VECTOR  16'hFFFC

// High address byte used by every zero-page access
`define CPU_ZERO_PAGE     8'h00

// JMP absolute
// Sitting in the opcode register at reset it reads the vector bytes
// as its operand and so loads PC from FFFC/FFFD
`define CPU_OPCODE_RESET  8'h4C

`endif

// ==== rtl/cpu_control.sv ====
`timescale 1ns/10ps

`include "cpu_config.svh"

module cpu_control (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       enable,
    input  logic [`CPU_DATA_WIDTH-1:0] data_in,
    input  cpu_pkg::flags_t            flags,
    input  logic                       branch_cross,
    output cpu_pkg::control_t          ctrl,
    output cpu_pkg::opcode_word_t      opcode,
    output logic                       sync
);

    cpu_pkg::cpu_state_t state;
    cpu_pkg::cpu_state_t next_state;

    logic       is_alu_imm;
    logic       is_alu_zp;
    logic       is_alu;
    logic       is_store;
    logic       is_load;
    logic       is_compare;
    logic       is_add_sub;
    logic       is_shift;
    logic       is_flag_set;
    logic       is_jump;
    logic       is_branch;
    logic [3:0] branch_flags;
    logic       branch_taken;

    // Group 01 opcodes in immediate or zero-page mode
    // STA immediate does not exist and falls through as a no-op
    assign is_alu_imm = (opcode.group_view.group == 2'b01)
                      & (opcode.group_view.mode == 3'b010)
                      & (opcode.group_view.operation != 3'b100);
    assign is_alu_zp  = (opcode.group_view.group == 2'b01)
                      & (opcode.group_view.mode == 3'b001);
    assign is_alu     = is_alu_imm | is_alu_zp;

    assign is_store   = is_alu_zp & (opcode.group_view.operation == 3'b100);
    assign is_load    = is_alu & (opcode.group_view.operation == 3'b101);
    assign is_compare = is_alu & (opcode.group_view.operation == 3'b110);
    assign is_add_sub = is_alu & (opcode.group_view.operation[1:0] == 2'b11); // ADC or SBC

    // ASL ROL LSR ROR on A
    assign is_shift    = (opcode.group_view.group == 2'b10)
                       & (opcode.group_view.mode == 3'b010)
                       & ~opcode.group_view.operation[2];
    // CLC 18 and SEC 38
    assign is_flag_set = (opcode.group_view.group == 2'b00)
                       & (opcode.group_view.mode == 3'b110)
                       & (opcode.group_view.operation[2:1] == 2'b00);
    assign is_jump     = (opcode.group_view.group == 2'b00)
                       & (opcode.group_view.mode == 3'b011)
                       & (opcode.group_view.operation == 3'b010);

    // BPL BMI BVC BVS BCC BCS BNE BEQ
    assign is_branch    = (opcode.branch_view.kind == 5'b10000);
    assign branch_flags = {flags.z, flags.c, flags.v, flags.n};
    assign branch_taken = (branch_flags[opcode.branch_view.flag_select]
                           == opcode.branch_view.expected);

    assign sync = state.byte1;

    always_comb
    begin
        ctrl       = '0;
        next_state = '0;

        if (state.byte1)
        begin
            // Fetch opcode while the previous instruction commits
            next_state.byte2  = 1'b1;
            ctrl.pc_increment = 1'b1;

            if (is_load)
                ctrl.db_select = cpu_pkg::DB_DATA_IN;   // LDA bypasses the ALU
            else if (is_alu & ~is_store)
                ctrl.db_select = cpu_pkg::DB_ALU;
            else if (is_shift)
                ctrl.db_select = cpu_pkg::DB_SHIFT;

            ctrl.load_a        = (is_alu & ~is_store & ~is_compare) | is_shift;
            ctrl.nz_from_db    = (is_alu & ~is_store) | is_shift;   // CMP sets N and Z too
            ctrl.v_from_alu    = is_add_sub;
            ctrl.c_from_alu    = is_add_sub | is_compare;
            ctrl.c_from_shift  = is_shift;
            ctrl.c_from_opcode = is_flag_set;
        end

        if (state.byte2)
        begin
            // One-byte opcodes read here without moving PC
            ctrl.pc_increment     = is_alu | is_branch | is_jump;
            next_state.zero_page  = is_alu_zp;
            next_state.byte3      = is_jump;
            next_state.branch_low = is_branch & branch_taken;
            next_state.byte1      = ~(is_alu_zp | is_jump | (is_branch & branch_taken));
        end

        if (state.byte3)
        begin
            ctrl.pc_vector    = 1'b1;   // PC from the two operand bytes
            next_state.byte1  = 1'b1;
        end

        if (state.zero_page)
        begin
            ctrl.addr_zero_page = 1'b1;
            ctrl.write_store    = is_store;
            next_state.byte1    = 1'b1;
        end

        if (state.branch_low)
        begin
            ctrl.pc_branch_low     = 1'b1;
            next_state.branch_high = branch_cross;  // Target lies on another page
            next_state.byte1       = ~branch_cross;
        end

        if (state.branch_high)
        begin
            ctrl.pc_branch_high = 1'b1;
            next_state.byte1    = 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            // Start as JMP absolute in its operand cycle
            state  <= '{byte2: 1'b1, default: 1'b0};
            opcode <= `CPU_OPCODE_RESET;
        end
        else if (enable)
        begin
            state <= next_state;
            if (state.byte1)
                opcode <= data_in;
        end
    end

endmodule

// ==== rtl/cpu_datapath.sv ====
`timescale 1ns/10ps

`include "cpu_config.svh"

module cpu_datapath (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       enable,
    input  logic [`CPU_DATA_WIDTH-1:0] data_in,
    input  cpu_pkg::control_t          ctrl,
    input  cpu_pkg::opcode_word_t      opcode,
    output cpu_pkg::flags_t            flags,
    output logic                       branch_cross,
    output cpu_pkg::bus_out_t          bus
);

    logic [`CPU_ADDR_WIDTH-1:0]   pc;
    logic [`CPU_ADDR_WIDTH-1:0]   next_pc;
    logic [`CPU_DATA_WIDTH-1:0]   acc;
    logic [`CPU_DATA_WIDTH-1:0]   input_byte;     // Last byte read or written
    logic [`CPU_DATA_WIDTH+1:0]   branch_sum;
    logic [`CPU_DATA_WIDTH+1:0]   branch_reg;
    logic [`CPU_DATA_WIDTH-1:0]   branch_adjust;
    logic [`CPU_DATA_WIDTH-1:0]   db;
    logic [`CPU_DATA_WIDTH-1:0]   alu_result;
    logic                         alu_carry;
    logic                         alu_overflow;
    logic [`CPU_DATA_WIDTH-1:0]   shift_result;
    logic                         shift_carry;
    cpu_pkg::flags_t              next_flags;

    cpu_alu alu (
        .a         (acc),
        .b         (input_byte),
        .carry_in  (flags.c),
        .operation (opcode.group_view.operation),
        .result    (alu_result),
        .carry_out (alu_carry),
        .overflow  (alu_overflow)
    );

    cpu_shift shift (
        .value     (acc),
        .carry_in  (flags.c),
        .operation (opcode.group_view.operation),
        .result    (shift_result),
        .carry_out (shift_carry)
    );

    // Internal data bus
    always_comb
    begin
        case (ctrl.db_select)
            cpu_pkg::DB_DATA_IN: db = input_byte;
            cpu_pkg::DB_ALU:     db = alu_result;
            cpu_pkg::DB_SHIFT:   db = shift_result;
            default:             db = '0;
        endcase
    end

    always_comb
    begin
        next_flags = flags;
        if (ctrl.nz_from_db)
        begin
            next_flags.n = db[`CPU_DATA_WIDTH-1];
            next_flags.z = (db == '0);
        end
        if (ctrl.v_from_alu)
            next_flags.v = alu_overflow;
        if (ctrl.c_from_alu)
            next_flags.c = alu_carry;
        else if (ctrl.c_from_shift)
            next_flags.c = shift_carry;
        else if (ctrl.c_from_opcode)
            next_flags.c = opcode.group_view.operation[0];    // Bit 5 picks SEC
    end

    // PCL plus sign-extended offset with two carry bits
    assign branch_sum   = {2'b00, pc[`CPU_DATA_WIDTH-1:0]}
                        + {{2{input_byte[`CPU_DATA_WIDTH-1]}}, input_byte};
    assign branch_cross = (branch_sum[`CPU_DATA_WIDTH+1:`CPU_DATA_WIDTH] != 2'b00);
    // Plus one forward or minus one backward
    assign branch_adjust = {{(`CPU_DATA_WIDTH-1){branch_reg[`CPU_DATA_WIDTH+1]}},
                            branch_reg[`CPU_DATA_WIDTH]};

    always_comb
    begin
        next_pc = pc + {{(`CPU_ADDR_WIDTH-1){1'b0}}, ctrl.pc_increment};
        if (ctrl.pc_branch_low)
            next_pc = {pc[`CPU_ADDR_WIDTH-1:`CPU_DATA_WIDTH], branch_sum[`CPU_DATA_WIDTH-1:0]};
        else if (ctrl.pc_branch_high)
            next_pc = {pc[`CPU_ADDR_WIDTH-1:`CPU_DATA_WIDTH] + branch_adjust,
                       pc[`CPU_DATA_WIDTH-1:0]};
        else if (ctrl.pc_vector)
            next_pc = {data_in, input_byte};    // High byte arrives now
    end

    // Outside bus
    always_comb
    begin
        bus.address      = ctrl.addr_zero_page ? {`CPU_ZERO_PAGE, input_byte} : pc;
        bus.data_out     = ctrl.write_store ? acc : '0;
        bus.write_enable = ctrl.write_store;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            pc    <= `CPU_RESET_VECTOR;
            flags <= '0;
        end
        else if (enable)
        begin
            pc    <= next_pc;
            flags <= next_flags;
        end
    end

    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            if (ctrl.load_a)
                acc <= db;
            branch_reg <= branch_sum;   // Used by branch_high one cycle later
            // A written byte reads back as itself
            input_byte <= bus.write_enable ? bus.data_out : data_in;
        end
    end

endmodule

// ==== rtl/cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

    // One-hot cycle state
    typedef struct packed {
        logic byte1;        // Opcode fetch and commit of previous instruction
        logic byte2;        // Operand or zero-page address byte
        logic byte3;        // High byte of JMP target
        logic zero_page;    // Zero-page read or store
        logic branch_low;   // Offset added into PCL
        logic branch_high;  // Page carry into PCH
    } cpu_state_t;

    // Opcode byte in two decodings
    typedef union packed {
        struct packed {
            logic [2:0] operation;  // ORA AND EOR ADC STA LDA CMP SBC
            logic [2:0] mode;       // 001 zero page, 010 immediate or accumulator
            logic [1:0] group;      // 01 ALU, 10 shift
        } group_view;
        struct packed {
            logic [1:0] flag_select;  // N V C Z
            logic       expected;     // Branch when flag equals this
            logic [4:0] kind;         // 10000 for all branches
        } branch_view;
    } opcode_word_t;

    // Internal data bus source
    typedef enum logic [1:0] {
        DB_NONE,
        DB_DATA_IN,
        DB_ALU,
        DB_SHIFT
    } db_select_t;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } flags_t;

    // Per-cycle datapath controls
    typedef struct packed {
        logic       pc_increment;    // PC + 1
        logic       pc_branch_low;   // PCL from branch sum
        logic       pc_branch_high;  // PCH adjusted by branch carry
        logic       pc_vector;       // PC from last two bytes read
        logic       addr_zero_page;  // Address is zero page plus last byte read
        logic       write_store;     // Drive A onto the bus and write
        db_select_t db_select;
        logic       load_a;          // A takes the data bus
        logic       nz_from_db;
        logic       v_from_alu;
        logic       c_from_alu;
        logic       c_from_shift;
        logic       c_from_opcode;   // CLC and SEC
    } control_t;

    // Outside memory bus
    typedef struct packed {
        logic [`CPU_ADDR_WIDTH-1:0] address;
        logic [`CPU_DATA_WIDTH-1:0] data_out;
        logic                       write_enable;
    } bus_out_t;

endpackage

// ==== rtl/cpu_shift.sv ====
`timescale 1ns/10ps

`include "cpu_config.svh"

module cpu_shift (
    input  logic [`CPU_DATA_WIDTH-1:0] value,
    input  logic                       carry_in,
    input  logic [2:0]                 operation,   // ASL ROL LSR ROR
    output logic [`CPU_DATA_WIDTH-1:0] result,
    output logic                       carry_out
);

    logic rotate;
    logic right;
    logic fill;

    assign rotate = operation[0];
    assign right  = operation[1];
    assign fill   = carry_in & rotate;     // Bit shifted in

    always_comb
    begin
        if (operation[2])
        begin
            // Upper operations do not shift
            result    = value;
            carry_out = carry_in;
        end
        else if (right)
            {result, carry_out} = {fill, value};    // LSR and ROR
        else
            {carry_out, result} = {value, fill};    // ASL and ROL
    end

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/10ps

`include "cpu_config.svh"

module cpu_top (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       enable,        // Clock enable for stalls
    input  logic [`CPU_DATA_WIDTH-1:0] data_in,       // Asynchronous read data
    output logic [`CPU_ADDR_WIDTH-1:0] address,
    output logic [`CPU_DATA_WIDTH-1:0] data_out,
    output logic                       write_enable,
    output logic                       sync           // Opcode fetch cycle
);

    cpu_pkg::control_t     ctrl;
    cpu_pkg::opcode_word_t opcode;
    cpu_pkg::flags_t       flags;
    logic                  branch_cross;
    cpu_pkg::bus_out_t     bus;

    cpu_control control (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .flags        (flags),
        .branch_cross (branch_cross),
        .ctrl         (ctrl),
        .opcode       (opcode),
        .sync         (sync)
    );

    cpu_datapath datapath (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .ctrl         (ctrl),
        .opcode       (opcode),
        .flags        (flags),
        .branch_cross (branch_cross),
        .bus          (bus)
    );

    assign address      = bus.address;
    assign data_out     = bus.data_out;
    assign write_enable = bus.write_enable;

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/cpu_control.sv
rtl/cpu_alu.sv
rtl/cpu_shift.sv
rtl/cpu_datapath.sv
rtl/cpu_top.sv
bench/tb_memory.sv
bench/tb_cpu.sv
